/* all.f */
+incdir+include
src/fetch_pkg.sv
src/fetch_bus_if.sv
src/pc_gen.sv
src/icache.sv
src/axi_rd_master.sv
src/fetch_top.sv
tests/axi_rom_model.sv
tests/tb_fetch_top.sv

/* tests/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module tb_fetch_top import fetch_pkg::*; ();

  localparam int NROWS        = 10;
  localparam int CYC_PER_INST = 40;   // timeout budget per instruction

  logic               clk;
  logic               rst_n;
  logic               redirect;
  logic [`XLEN-1:0]   redirect_pc;
  logic               inst_valid;
  logic               inst_ready;
  logic [`INST_W-1:0] inst;
  logic [`XLEN-1:0]   inst_pc;
  logic               inst_err;
  logic               ar_valid;
  logic               ar_ready;
  logic [`XLEN-1:0]   ar_addr;
  logic               r_valid;
  logic               r_ready;
  logic [`XLEN-1:0]   r_data;
  logic [1:0]         r_resp;
  logic               r_last;

  // stimulus table, one row per test
  string            row_name  [NROWS];
  logic [`XLEN-1:0] row_pc    [NROWS];   // applied as redirect
  int               row_count [NROWS];   // instructions to receive
  bit               row_stall [NROWS];   // lfsr drives inst_ready
  bit               row_err   [NROWS];   // expected error flag
  bit               row_b2b   [NROWS];   // all hits, one per cycle

  logic [15:0]      lfsr_s;
  int               got;          // accepted in current row
  int               cyc;          // cycles in current row
  int               last_cyc;
  logic [`XLEN-1:0] exp_pc;
  bit               held;         // valid without ready last cycle
  fetch_rsp_t       held_rsp;
  fetch_rsp_t       got_rsp;
  int               cycles = 0;
  int               limit  = 0;
  int               n_checks;
  int               n_pc_err;
  int               n_inst_err;
  int               n_flag_err;
  int               n_hold_err;
  int               n_gap_err;

  fetch_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .inst_valid_o  (inst_valid),
    .inst_ready_i  (inst_ready),
    .inst_o        (inst),
    .inst_pc_o     (inst_pc),
    .inst_err_o    (inst_err),
    .ar_valid_o    (ar_valid),
    .ar_ready_i    (ar_ready),
    .ar_addr_o     (ar_addr),
    .r_valid_i     (r_valid),
    .r_ready_o     (r_ready),
    .r_data_i      (r_data),
    .r_resp_i      (r_resp),
    .r_last_i      (r_last)
  );

  axi_rom_model #(.SEED(16'd94)) i_rom (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .r_last_o   (r_last)
  );

  always #2 clk = ~clk;   // 4 ns period

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int total_errors();
    return n_pc_err + n_inst_err + n_flag_err + n_hold_err + n_gap_err;
  endfunction

  task automatic set_row(input int i, input string name, input logic [`XLEN-1:0] pc,
                         input int n, input bit stall, input bit err, input bit b2b);
    row_name[i]  = name;
    row_pc[i]    = pc;
    row_count[i] = n;
    row_stall[i] = stall;
    row_err[i]   = err;
    row_b2b[i]   = b2b;
  endtask

  task automatic fill_table();
    set_row(0, "cold_seq",     64'h8000_0000, 24, 1'b0, 1'b0, 1'b0);
    set_row(1, "refetch_hit",  64'h8000_0000, 24, 1'b0, 1'b0, 1'b1);  // lines 0..5 warm
    set_row(2, "redirect_mid", 64'h8000_0340, 12, 1'b0, 1'b0, 1'b0);
    set_row(3, "ready_stall",  64'h8000_0400, 32, 1'b1, 1'b0, 1'b0);
    set_row(4, "err_window",   64'h8000_1000,  8, 1'b0, 1'b1, 1'b0);
    set_row(5, "err_refetch",  64'h8000_1000,  8, 1'b1, 1'b1, 1'b0);  // must miss again
    set_row(6, "conflict_a",   64'h8000_2000,  4, 1'b0, 1'b0, 1'b0);  // index 0
    set_row(7, "conflict_b",   64'h8000_2100,  4, 1'b0, 1'b0, 1'b0);  // index 0, new tag
    set_row(8, "conflict_a2",  64'h8000_2000,  4, 1'b0, 1'b0, 1'b0);
    set_row(9, "conflict_b2",  64'h8000_2100,  4, 1'b0, 1'b0, 1'b0);
  endtask

  task drive_ready(input bit stall);
    if (stall) begin
      lfsr_s = lfsr_next(lfsr_s);  // one bit per cycle
      inst_ready <= lfsr_s[0];
    end else begin
      inst_ready <= 1'b1;
    end
  endtask

  // called at negedge, the handshake seen here lands on the next posedge
  task automatic sample_output(input int i);
    logic [`INST_W-1:0] exp_inst;
    got_rsp.pc   = inst_pc;
    got_rsp.inst = inst;
    got_rsp.err  = inst_err;
    if (held) begin
      n_checks += 2;
      assert (inst_valid) else begin
        n_hold_err++;
        $display("%s: output dropped while stalled at pc %h", row_name[i], held_rsp.pc);
      end
      assert (got_rsp == held_rsp) else begin
        n_hold_err++;
        $display("[FAIL] %s hold: expected %h actual %h", row_name[i], held_rsp, got_rsp);
      end
    end
    if (inst_valid && inst_ready) begin
      exp_inst = exp_pc[31:0] ^ 32'h0000_0013;
      n_checks += 3;
      assert (inst_pc == exp_pc) else begin
        n_pc_err++;
        $display("[FAIL] %s pc: expected %h actual %h", row_name[i], exp_pc, inst_pc);
      end
      assert (inst == exp_inst) else begin
        n_inst_err++;
        $display("[FAIL] %s inst: expected %h actual %h", row_name[i], exp_inst, inst);
      end
      assert (inst_err == row_err[i]) else begin
        n_flag_err++;
        $display("[FAIL] %s err: expected %0b actual %0b", row_name[i], row_err[i], inst_err);
      end
      if (row_b2b[i] && got > 0) begin
        n_checks++;
        assert (cyc == last_cyc + 1) else begin
          n_gap_err++;
          $display("[FAIL] %s hit spacing: expected 1 actual %0d", row_name[i],
                   cyc - last_cyc);
        end
      end
      last_cyc = cyc;
      got++;
      exp_pc += `XLEN'd4;
    end
    held     = inst_valid && !inst_ready;
    held_rsp = got_rsp;
  endtask

  // entered right after a posedge
  task automatic run_row(input int i);
    redirect    <= 1'b1;
    redirect_pc <= row_pc[i];
    inst_ready  <= 1'b0;   // nothing taken in the redirect cycle
    @(posedge clk);
    redirect <= 1'b0;
    drive_ready(row_stall[i]);
    got      = 0;
    cyc      = 0;
    last_cyc = 0;
    held     = 1'b0;
    exp_pc   = row_pc[i];
    while (got < row_count[i]) begin
      @(negedge clk);
      cyc++;
      sample_output(i);
      @(posedge clk);
      if (got < row_count[i]) drive_ready(row_stall[i]);
      else inst_ready <= 1'b0;   // stop right after the last transfer
    end
  endtask

  task print_summary();
    $display("summary: %0d checks, errors pc %0d inst %0d err %0d hold %0d timing %0d",
             n_checks, n_pc_err, n_inst_err, n_flag_err, n_hold_err, n_gap_err);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run not finished after %0d cycles", limit);
      print_summary();
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    inst_ready  = 1'b0;
    lfsr_s      = 16'd94;
    n_checks = 0;
    n_pc_err = 0;
    n_inst_err = 0;
    n_flag_err = 0;
    n_hold_err = 0;
    n_gap_err = 0;
    fill_table();
    limit = 200;
    for (int r = 0; r < NROWS; r++) limit += row_count[r] * CYC_PER_INST;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int r = 0; r < NROWS; r++) run_row(r);
    print_summary();
    if (total_errors() == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/axi_rom_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// AXI read slave with random handshake delays
module axi_rom_model #(
  parameter logic [15:0] SEED = 16'd94
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               ar_valid_i,
  output logic              ar_ready_o,
  input  wire [`XLEN-1:0]   ar_addr_i,
  output logic              r_valid_o,
  input  wire               r_ready_i,
  output logic [`XLEN-1:0]  r_data_o,
  output logic [1:0]        r_resp_o,
  output logic              r_last_o
);

  // any beat in here answers SLVERR
  localparam logic [`XLEN-1:0] ERR_LO = 64'h0000_0000_8000_1000;
  localparam logic [`XLEN-1:0] ERR_HI = 64'h0000_0000_8000_10FF;

  logic [15:0]      lfsr_s;   // delay source
  logic             busy_q;   // burst accepted, beats pending
  logic [1:0]       wait_q;   // cycles before next ready/valid
  logic [`XLEN-1:0] addr_q;   // address of the current beat
  int               beat_q;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // every 32-bit word is its own byte address xor 0x13
  function automatic logic [31:0] rom_word(input logic [`XLEN-1:0] a);
    return a[31:0] ^ 32'h0000_0013;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_s = SEED;
      busy_q     <= 1'b0;
      wait_q     <= 2'd0;
      addr_q     <= '0;
      beat_q     <= 0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_resp_o   <= 2'b00;
      r_last_o   <= 1'b0;
    end else if (!busy_q) begin
      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        busy_q     <= 1'b1;
        addr_q     <= ar_addr_i;
        beat_q     <= 0;
        lfsr_s = lfsr_next(lfsr_next(lfsr_s));  // one step per delay bit
        wait_q     <= lfsr_s[1:0];
      end else if (ar_valid_i) begin
        if (wait_q == 2'd0) ar_ready_o <= 1'b1;
        else wait_q <= wait_q - 2'd1;
      end
    end else if (r_valid_o && r_ready_i) begin
      r_valid_o <= 1'b0;
      busy_q    <= !r_last_o;   // burst closes on last beat
      addr_q    <= addr_q + `XLEN'd8;
      beat_q    <= beat_q + 1;
      lfsr_s = lfsr_next(lfsr_next(lfsr_s));
      wait_q    <= lfsr_s[1:0];  // also the AR delay of the next burst
    end else if (!r_valid_o) begin
      if (wait_q == 2'd0) begin
        r_valid_o <= 1'b1;
        r_data_o  <= {rom_word(addr_q + `XLEN'd4), rom_word(addr_q)};  // little endian
        r_resp_o  <= (addr_q >= ERR_LO && addr_q <= ERR_HI) ? 2'b10 : 2'b00;
        r_last_o  <= (beat_q == `IC_BEATS - 1);
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_top (
  input  wire                clk,
  input  wire                rst_n,
  // redirect from later stages
  input  wire                redirect_i,
  input  wire [`XLEN-1:0]    redirect_pc_i,
  // decoder port
  output wire                inst_valid_o,
  input  wire                inst_ready_i,
  output wire [`INST_W-1:0]  inst_o,
  output wire [`XLEN-1:0]    inst_pc_o,
  output wire                inst_err_o,
  // AXI read, AR
  output wire                ar_valid_o,
  input  wire                ar_ready_i,
  output wire [`XLEN-1:0]    ar_addr_o,
  // AXI read, R
  input  wire                r_valid_i,
  output wire                r_ready_o,
  input  wire [`XLEN-1:0]    r_data_i,
  input  wire [1:0]          r_resp_i,
  input  wire                r_last_i
);

  fetch_req_if req_bus ();   // pc_gen -> icache
  refill_if    fill_bus ();  // icache -> axi master

  pc_gen i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .req           (req_bus)
  );

  icache i_icache (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req_bus),
    .fill         (fill_bus),
    .inst_valid_o (inst_valid_o),
    .inst_ready_i (inst_ready_i),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_err_o   (inst_err_o)
  );

  axi_rd_master i_axi_rd_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill       (fill_bus),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .ar_addr_o  (ar_addr_o),
    .r_valid_i  (r_valid_i),
    .r_ready_o  (r_ready_o),
    .r_data_i   (r_data_i),
    .r_resp_i   (r_resp_i),
    .r_last_i   (r_last_i)
  );

endmodule

`default_nettype wire

/* src/axi_rd_master.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module axi_rd_master (
  input  wire               clk,
  input  wire               rst_n,
  refill_if.responder       fill,
  // AR channel
  output logic              ar_valid_o,
  input  wire               ar_ready_i,
  output logic [`XLEN-1:0]  ar_addr_o,
  // R channel
  input  wire               r_valid_i,
  output logic              r_ready_o,
  input  wire [`XLEN-1:0]   r_data_i,
  input  wire [1:0]         r_resp_i,
  input  wire               r_last_i
);

  localparam logic [1:0] M_IDLE = 2'd0;
  localparam logic [1:0] M_ADDR = 2'd1;  // ar_valid up
  localparam logic [1:0] M_DATA = 2'd2;  // r_ready up
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic [1:0]            state_q;
  logic [1:0]            state_d;
  logic [`XLEN-1:0]      addr_q;       // latched line address
  logic [`IC_BEAT_W-1:0] beat_cnt_q;   // beats seen in this burst
  logic                  ar_fire;
  logic                  r_fire;

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_o;

  // grant only from idle, one line at a time
  assign fill.gnt = (state_q == M_IDLE) && fill.req;

  assign ar_valid_o = (state_q == M_ADDR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = (state_q == M_DATA);  // whole burst, no throttling

  // beats go straight through in the handshake cycle
  assign fill.beat_valid = r_fire;
  assign fill.beat_data  = r_data_i;
  assign fill.beat_last  = r_fire && r_last_i;
  assign fill.beat_err   = (r_resp_i != RESP_OKAY);  // SLVERR or DECERR

  always_comb begin
    state_d = state_q;
    case (state_q)
      M_IDLE:  if (fill.gnt) state_d = M_ADDR;
      M_ADDR:  if (ar_fire) state_d = M_DATA;
      M_DATA:  if (r_fire && r_last_i) state_d = M_IDLE;
      default: state_d = M_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= M_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (fill.gnt) begin
      addr_q <= fill.line_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
    end else if (ar_fire) begin
      beat_cnt_q <= '0;
    end else if (r_fire) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // AXI rule, address may not change before ar_ready
  a_ar_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ar_valid_o && !ar_ready_i) |=> (ar_valid_o && $stable(ar_addr_o))
  ) else $error("axi_rd_master: AR dropped or changed before ready");

  // slave must close the burst exactly at the fixed length
  a_last_beat: assert property (
    @(posedge clk) disable iff (!rst_n)
    r_fire |-> (r_last_i == (beat_cnt_q == `AXI_AR_LEN))
  ) else $error("axi_rd_master: r_last on beat %0d", beat_cnt_q);

endmodule

`default_nettype wire

/* src/icache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module icache import fetch_pkg::*; (
  input  wire                 clk,
  input  wire                 rst_n,
  fetch_req_if.consumer       req,
  refill_if.requester         fill,
  output logic                inst_valid_o,
  input  wire                 inst_ready_i,
  output logic [`INST_W-1:0]  inst_o,
  output logic [`XLEN-1:0]    inst_pc_o,
  output logic                inst_err_o
);

  // refill fsm
  localparam logic [1:0] S_IDLE  = 2'd0;  // lookup and hit path live
  localparam logic [1:0] S_REQ   = 2'd1;  // asking master for a line
  localparam logic [1:0] S_WAIT  = 2'd2;  // beats coming in
  localparam logic [1:0] S_WRITE = 2'd3;  // line complete, write + present

  logic [1:0] state_q;
  logic [1:0] state_d;

  // arrays, only valid bits are cleared
  logic [`IC_LINES-1:0] valid_q;
  logic [`IC_TAG_W-1:0] tag_q  [`IC_LINES];
  logic [`XLEN-1:0]     data_q [`IC_LINES][`IC_BEATS];

  // lookup stage
  logic                   lk_valid_q;
  fetch_addr_u            lk_addr_q;
  logic [`IC_INDEX_W-1:0] lk_idx;
  logic                   lk_hit;
  logic [`XLEN-1:0]       hit_beat;
  logic [`XLEN-1:0]       fill_beat;
  logic [`INST_W-1:0]     hit_inst;
  logic [`INST_W-1:0]     fill_inst;

  // refill assembly
  logic [`XLEN-1:0]     line_buf_q [`IC_BEATS];
  logic [`IC_BEAT_W-1:0] beat_cnt_q;
  logic                 line_err_q;   // any beat with bad resp
  logic                 drop_q;       // flushed mid refill, do not present

  // output register
  fetch_rsp_t out_q;
  logic       out_valid_q;

  logic req_fire;
  logic out_free;
  logic hit_load;
  logic fill_load;
  logic miss_start;
  logic leave_write;

  assign lk_idx = lk_addr_q.f.index;
  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_addr_q.f.tag);

  assign hit_beat  = data_q[lk_idx][lk_addr_q.f.beat];
  assign fill_beat = line_buf_q[lk_addr_q.f.beat];
  assign hit_inst  = hit_beat[lk_addr_q.f.word * `INST_W +: `INST_W];
  assign fill_inst = fill_beat[lk_addr_q.f.word * `INST_W +: `INST_W];

  assign out_free    = !out_valid_q || inst_ready_i;  // slot empty or leaving now
  assign hit_load    = (state_q == S_IDLE) && lk_valid_q && lk_hit && out_free && !req.flush;
  assign miss_start  = (state_q == S_IDLE) && lk_valid_q && !lk_hit && !req.flush;
  assign leave_write = (state_q == S_WRITE) && (out_free || drop_q || req.flush);
  assign fill_load   = leave_write && !drop_q && !req.flush;

  // take a new pc only if the pending one moves on this cycle
  // a flush throws away both stages, so it always frees a slot in idle
  assign req.ready = (state_q == S_IDLE) &&
                     (req.flush || (out_free && (!lk_valid_q || lk_hit)));
  assign req_fire  = req.valid && req.ready;

  assign fill.req       = (state_q == S_REQ);
  assign fill.line_addr = {lk_addr_q.raw[`XLEN-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (miss_start) state_d = S_REQ;
      S_REQ:   if (fill.gnt) state_d = S_WAIT;
      S_WAIT:  if (fill.beat_valid && fill.beat_last) state_d = S_WRITE;
      S_WRITE: if (leave_write) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lk_valid_q <= 1'b0;
    end else if (req_fire) begin
      lk_valid_q <= 1'b1;
    end else if (req.flush || hit_load || leave_write) begin
      lk_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      lk_addr_q.raw <= req.pc;  // stays put for the whole refill
    end
  end

  // beat counter and error collect, restart on each grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
      line_err_q <= 1'b0;
      drop_q     <= 1'b0;
    end else begin
      if (fill.gnt) begin
        beat_cnt_q <= '0;
        line_err_q <= 1'b0;
      end else if (fill.beat_valid) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        line_err_q <= line_err_q | fill.beat_err;
      end
      // burst cannot be cancelled, just remember to hide the result
      if (leave_write) begin
        drop_q <= 1'b0;
      end else if (req.flush && (state_q != S_IDLE)) begin
        drop_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill.beat_valid) begin
      line_buf_q[beat_cnt_q] <= fill.beat_data;
    end
  end

  // erroring line stays invalid so a refetch goes to the bus again
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (leave_write) begin
      valid_q[lk_idx] <= !line_err_q;
    end
  end

  always_ff @(posedge clk) begin
    if (leave_write && !line_err_q) begin
      tag_q[lk_idx] <= lk_addr_q.f.tag;
      for (int b = 0; b < `IC_BEATS; b++) begin
        data_q[lk_idx][b] <= line_buf_q[b];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (hit_load || fill_load) begin
      out_valid_q <= 1'b1;
    end else if (req.flush || inst_ready_i) begin
      out_valid_q <= 1'b0;  // taken by decode or squashed
    end
  end

  always_ff @(posedge clk) begin
    if (hit_load || fill_load) begin
      out_q.pc   <= lk_addr_q.raw;
      out_q.inst <= hit_load ? hit_inst : fill_inst;
      out_q.err  <= fill_load && line_err_q;
    end
  end

  // squashed in the flush cycle as well
  assign inst_valid_o = out_valid_q && !req.flush;
  assign inst_o       = out_q.inst;
  assign inst_pc_o    = out_q.pc;
  assign inst_err_o   = out_q.err;

  // data comes from array or line buffer, both written by refill only
  a_inst_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    inst_valid_o |-> !$isunknown(inst_o)
  ) else $error("icache: unknown instruction at pc %h", inst_pc_o);

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module pc_gen import fetch_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               redirect_i,     // from a later stage
  input  wire [`XLEN-1:0]   redirect_pc_i,
  fetch_req_if.producer     req
);

  fetch_addr_u      pc_q;
  logic [`XLEN-1:0] pc_seq;   // sequential successor
  logic             run_q;    // goes high one cycle out of reset
  logic             flush_q;
  logic             req_fire;

  assign req_fire = req.valid && req.ready;
  assign pc_seq   = pc_q.raw + `XLEN'd4;  // no prediction, always +4

  // request always pending once running
  assign req.valid = run_q;
  assign req.pc    = pc_q.raw;
  assign req.flush = flush_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // redirect wins over a sequential step in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q.raw <= `RESET_PC;
    end else if (redirect_i) begin
      pc_q.raw <= redirect_pc_i;
    end else if (req_fire) begin
      pc_q.raw <= pc_seq;
    end
  end

  // flush goes out together with the new pc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= redirect_i;
    end
  end

  // redirect targets come from outside, so alignment is checked here
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    req.valid |-> (pc_q.f.byte_off == 2'b00)
  ) else $error("pc_gen: misaligned pc %h", pc_q.raw);

  // icache relies on the pc not moving under back-pressure
  a_pc_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req.valid && !req.ready && !redirect_i) |=> $stable(req.pc)
  ) else $error("pc_gen: pc changed while stalled");

endmodule

`default_nettype wire

/* src/fetch_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// pc_gen to icache request channel
interface fetch_req_if;
  logic             valid;
  logic             ready;
  logic [`XLEN-1:0] pc;     // held while valid && !ready
  logic             flush;  // single cycle, comes with the redirect pc

  modport producer (output valid, output pc, output flush, input ready);
  modport consumer (input valid, input pc, input flush, output ready);
endinterface

// icache to AXI master line refill channel
interface refill_if;
  logic             req;         // held until gnt
  logic             gnt;
  logic [`XLEN-1:0] line_addr;   // line aligned
  logic             beat_valid;  // no back-pressure, cache always takes it
  logic [`XLEN-1:0] beat_data;
  logic             beat_last;
  logic             beat_err;

  modport requester (output req, output line_addr, input gnt,
                     input beat_valid, input beat_data, input beat_last, input beat_err);
  modport responder (input req, input line_addr, output gnt,
                     output beat_valid, output beat_data, output beat_last, output beat_err);
endinterface

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none
`include "fetch_settings.svh"

package fetch_pkg;

  // field view of a fetch address, msb first
  // beat + word + byte_off add up to IC_OFFSET_W
  typedef struct packed {
    logic [`IC_TAG_W-1:0]   tag;      // compared against tag array
    logic [`IC_INDEX_W-1:0] index;    // line select
    logic [`IC_BEAT_W-1:0]  beat;     // 64-bit beat within line
    logic                   word;     // upper or lower half of beat
    logic [1:0]             byte_off; // zero for aligned fetch
  } fetch_addr_fields_t;

  // same 64 bits, raw for pc arithmetic, fields for lookup
  typedef union packed {
    logic [`XLEN-1:0]   raw;
    fetch_addr_fields_t f;
  } fetch_addr_u;

  // one fetched instruction as handed to decode
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`INST_W-1:0] inst;
    logic               err;   // bus error on the line it came from
  } fetch_rsp_t;

endpackage

`default_nettype wire

/* include/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// datapath
`define XLEN        64   // address and AXI data width
`define INST_W      32   // no compressed insts

// icache geometry
`define IC_INDEX_W  4    // 16 lines
`define IC_LINES    (1 << `IC_INDEX_W)
`define IC_BEATS    2    // 64-bit beats per line
`define IC_BEAT_W   1    // log2 of IC_BEATS
`define IC_OFFSET_W 4    // 16 byte line, 4 insts
`define IC_TAG_W    (`XLEN - `IC_INDEX_W - `IC_OFFSET_W)

// fixed INCR burst, AXI len field is beats minus one
`define AXI_AR_LEN  (`IC_BEATS - 1)

// boot vector
`define RESET_PC    64'h0000_0000_8000_0000

`endif
